// ==== lrelu_defines.svh ====
`ifndef LRELU_DEFINES_SVH
`define LRELU_DEFINES_SVH

// beat shape
`define LRELU_UNITS       4
`define LRELU_WORD_IN     20
`define LRELU_WORD_OUT    8
`define LRELU_WORD_CFG    16
`define LRELU_TAG_WIDTH   3

// internal headroom for products and sums
`define LRELU_ACC_WIDTH   40

// A is a signed fixed-point value with 8 fraction bits
`define LRELU_FRAC_BITS   8

// leaky slope 13/128 near 0.1
`define LRELU_ALPHA       13
`define LRELU_ALPHA_SHIFT 7

// saturation bounds of the output word
`define LRELU_OUT_MAX     127
`define LRELU_OUT_MIN     (-128)

`endif

// ==== lrelu_pkg.sv ====
`include "lrelu_defines.svh"

package lrelu_pkg;

  // single words
  typedef logic signed [`LRELU_WORD_IN-1:0]   word_in_t;
  typedef logic signed [`LRELU_WORD_OUT-1:0]  word_out_t;
  typedef logic signed [`LRELU_ACC_WIDTH-1:0] acc_t;

  // user tag riding beside the data
  typedef struct packed {
    logic                        is_lrelu;
    logic [`LRELU_TAG_WIDTH-1:0] tag;
  } lrelu_user_t;

  // sideband of one beat
  typedef struct packed {
    logic        valid;
    logic        last;
    lrelu_user_t user;
  } beat_ctl_t;

  // one beat of UNITS words
  typedef word_in_t  [`LRELU_UNITS-1:0] data_in_t;
  typedef acc_t      [`LRELU_UNITS-1:0] acc_vec_t;
  typedef word_out_t [`LRELU_UNITS-1:0] data_out_t;

endpackage

// ==== lrelu_cfg_pkg.sv ====
`include "lrelu_defines.svh"

package lrelu_cfg_pkg;

  typedef logic signed [`LRELU_WORD_CFG-1:0] cfg_word_t;
  typedef logic [$clog2(`LRELU_UNITS)-1:0]   unit_idx_t;

  // load order is D, then the A words, then the B words
  typedef enum logic [1:0] {
    LOAD_D,
    LOAD_A,
    LOAD_B
  } load_state_e;

  typedef struct packed {
    load_state_e state;
    unit_idx_t   unit_idx;
  } cfg_sel_t;

  typedef struct packed {
    cfg_word_t                    d;
    cfg_word_t [`LRELU_UNITS-1:0] a;
    cfg_word_t [`LRELU_UNITS-1:0] b;
  } coef_set_t;

endpackage

// ==== lrelu_config_ctrl.sv ====
`include "lrelu_defines.svh"

module lrelu_config_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clken,
  input  logic                    cfg_valid,
  output logic                    cfg_we,
  output lrelu_cfg_pkg::cfg_sel_t cfg_sel,
  output logic                    count_config_full
);
  import lrelu_cfg_pkg::*;

  localparam int LAST_UNIT = `LRELU_UNITS - 1;

  load_state_e state;
  load_state_e state_next;
  unit_idx_t   unit_idx;
  unit_idx_t   unit_next;
  logic        last_word;

  // a word is taken on every enabled strobe, no handshake
  assign cfg_we         = cfg_valid && clken;
  assign cfg_sel.state    = state;
  assign cfg_sel.unit_idx = unit_idx;
  assign last_word      = (state == LOAD_B) && (unit_idx == unit_idx_t'(LAST_UNIT));

  always_comb begin
    state_next = state;
    unit_next  = unit_idx;
    case (state)
      LOAD_D: begin
        state_next = LOAD_A;
        unit_next  = '0;
      end
      LOAD_A: begin
        if (unit_idx == unit_idx_t'(LAST_UNIT)) begin
          state_next = LOAD_B;
          unit_next  = '0;
        end else begin
          unit_next = unit_idx + 1'b1;
        end
      end
      LOAD_B: begin
        if (last_word) begin
          state_next = LOAD_D;
          unit_next  = '0;
        end else begin
          unit_next = unit_idx + 1'b1;
        end
      end
      default: begin
        state_next = LOAD_D;
        unit_next  = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= LOAD_D;
      unit_idx          <= '0;
      count_config_full <= 1'b0;
    end else if (cfg_we) begin
      state             <= state_next;
      unit_idx          <= unit_next;
      // set by B[last], cleared by any following word
      count_config_full <= last_word;
    end
  end

  a_sel_legal: assert property (@(posedge clk) disable iff (rst)
    (int'(unit_idx) < `LRELU_UNITS) && (state inside {LOAD_D, LOAD_A, LOAD_B}));

endmodule

// ==== lrelu_coef_bank.sv ====
`include "lrelu_defines.svh"

module lrelu_coef_bank (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clken,
  input  logic                     cfg_we,
  input  lrelu_cfg_pkg::cfg_sel_t  cfg_sel,
  input  lrelu_cfg_pkg::cfg_word_t cfg_data,
  output lrelu_cfg_pkg::coef_set_t coefs
);
  import lrelu_cfg_pkg::*;

  logic                    d_we;
  logic [`LRELU_UNITS-1:0] a_we;
  logic [`LRELU_UNITS-1:0] b_we;

  // one write slot per accepted word
  always_comb begin
    d_we = 1'b0;
    a_we = '0;
    b_we = '0;
    if (cfg_we) begin
      case (cfg_sel.state)
        LOAD_D:  d_we = 1'b1;
        LOAD_A:  a_we[cfg_sel.unit_idx] = 1'b1;
        LOAD_B:  b_we[cfg_sel.unit_idx] = 1'b1;
        default: d_we = 1'b0;
      endcase
    end
  end

  // new values reach the stages on the next enabled edge
  always_ff @(posedge clk) begin
    if (rst) begin
      coefs <= '0;
    end else if (clken) begin
      if (d_we) begin
        coefs.d <= cfg_data;
      end
      for (int u = 0; u < `LRELU_UNITS; u++) begin
        if (a_we[u]) begin
          coefs.a[u] <= cfg_data;
        end
        if (b_we[u]) begin
          coefs.b[u] <= cfg_data;
        end
      end
    end
  end

  a_we_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(cfg_we));

endmodule

// ==== lrelu_affine_stage.sv ====
`include "lrelu_defines.svh"

module lrelu_affine_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clken,
  input  lrelu_pkg::beat_ctl_t     in_ctl,
  input  lrelu_pkg::data_in_t      in_data,
  input  lrelu_cfg_pkg::coef_set_t coefs,
  output lrelu_pkg::beat_ctl_t     out_ctl,
  output lrelu_pkg::acc_vec_t      out_data
);
  import lrelu_pkg::*;
  import lrelu_cfg_pkg::*;

  beat_ctl_t                    ctl_1;
  acc_vec_t                     prod_1;
  cfg_word_t [`LRELU_UNITS-1:0] b_1;

  // sideband follows the data two enabled cycles behind
  always_ff @(posedge clk) begin
    if (rst) begin
      ctl_1   <= '0;
      out_ctl <= '0;
    end else if (clken) begin
      ctl_1   <= in_ctl;
      out_ctl <= ctl_1;
    end
  end

  // cycle one: x * A, with B captured from the same coefficient set
  always_ff @(posedge clk) begin
    if (clken) begin
      for (int u = 0; u < `LRELU_UNITS; u++) begin
        prod_1[u] <= acc_t'($signed(in_data[u])) * acc_t'($signed(coefs.a[u]));
        b_1[u]    <= coefs.b[u];
      end
    end
  end

  // cycle two: floor away the fraction bits, then add B
  always_ff @(posedge clk) begin
    if (clken) begin
      for (int u = 0; u < `LRELU_UNITS; u++) begin
        out_data[u] <= ($signed(prod_1[u]) >>> `LRELU_FRAC_BITS)
                     + acc_t'($signed(b_1[u]));
      end
    end
  end

endmodule

// ==== lrelu_leaky_stage.sv ====
`include "lrelu_defines.svh"

module lrelu_leaky_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clken,
  input  lrelu_pkg::beat_ctl_t     in_ctl,
  input  lrelu_pkg::acc_vec_t      in_data,
  input  lrelu_cfg_pkg::coef_set_t coefs,
  output lrelu_pkg::beat_ctl_t     out_ctl,
  output lrelu_pkg::data_out_t     out_data
);
  import lrelu_pkg::*;
  import lrelu_cfg_pkg::*;

  localparam acc_t OUT_MAX = acc_t'(`LRELU_OUT_MAX);
  localparam acc_t OUT_MIN = acc_t'(`LRELU_OUT_MIN);

  beat_ctl_t ctl_1;
  acc_vec_t  q_1;
  cfg_word_t d_1;
  acc_vec_t  sum;

  always_ff @(posedge clk) begin
    if (rst) begin
      ctl_1   <= '0;
      out_ctl <= '0;
    end else if (clken) begin
      ctl_1   <= in_ctl;
      out_ctl <= ctl_1;
    end
  end

  // cycle one: scale negatives by alpha on lrelu beats
  always_ff @(posedge clk) begin
    if (clken) begin
      d_1 <= coefs.d;
      for (int u = 0; u < `LRELU_UNITS; u++) begin
        if (in_ctl.user.is_lrelu && in_data[u][`LRELU_ACC_WIDTH-1]) begin
          q_1[u] <= ($signed(in_data[u]) * `LRELU_ALPHA) >>> `LRELU_ALPHA_SHIFT;
        end else begin
          q_1[u] <= in_data[u];
        end
      end
    end
  end

  always_comb begin
    for (int u = 0; u < `LRELU_UNITS; u++) begin
      sum[u] = $signed(q_1[u]) + acc_t'($signed(d_1));
    end
  end

  // cycle two: add D and clamp to the output word
  always_ff @(posedge clk) begin
    if (clken) begin
      for (int u = 0; u < `LRELU_UNITS; u++) begin
        if ($signed(sum[u]) > OUT_MAX) begin
          out_data[u] <= word_out_t'(OUT_MAX);
        end else if ($signed(sum[u]) < OUT_MIN) begin
          out_data[u] <= word_out_t'(OUT_MIN);
        end else begin
          out_data[u] <= word_out_t'(sum[u]);
        end
      end
    end
  end

  // the clamp must never wrap a large sum into the opposite sign
  for (genvar u = 0; u < `LRELU_UNITS; u++) begin : g_clamp_chk
    a_clamp_sign: assert property (@(posedge clk) disable iff (rst)
      (clken && ctl_1.valid) |=>
        out_data[u][`LRELU_WORD_OUT-1] == $past(sum[u][`LRELU_ACC_WIDTH-1]));
  end

endmodule

// ==== lrelu_engine.sv ====
module lrelu_engine (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clken,
  input  logic                     s_valid,
  input  logic                     s_last,
  input  lrelu_pkg::lrelu_user_t   s_user,
  input  lrelu_pkg::data_in_t      s_data,
  input  logic                     cfg_valid,
  input  lrelu_cfg_pkg::cfg_word_t cfg_data,
  output logic                     m_valid,
  output logic                     m_last,
  output lrelu_pkg::lrelu_user_t   m_user,
  output lrelu_pkg::data_out_t     m_data,
  output logic                     count_config_full
);
  import lrelu_pkg::*;
  import lrelu_cfg_pkg::*;

  beat_ctl_t s_ctl;
  beat_ctl_t mid_ctl;
  beat_ctl_t m_ctl;
  acc_vec_t  mid_data;
  cfg_sel_t  cfg_sel;
  logic      cfg_we;
  coef_set_t coefs;

  // input sideband travels as one struct
  assign s_ctl.valid = s_valid;
  assign s_ctl.last  = s_last;
  assign s_ctl.user  = s_user;

  assign m_valid = m_ctl.valid;
  assign m_last  = m_ctl.last;
  assign m_user  = m_ctl.user;

  lrelu_config_ctrl ctrl_i (
    .clk               (clk),
    .rst               (rst),
    .clken             (clken),
    .cfg_valid         (cfg_valid),
    .cfg_we            (cfg_we),
    .cfg_sel           (cfg_sel),
    .count_config_full (count_config_full)
  );

  lrelu_coef_bank bank_i (
    .clk      (clk),
    .rst      (rst),
    .clken    (clken),
    .cfg_we   (cfg_we),
    .cfg_sel  (cfg_sel),
    .cfg_data (cfg_data),
    .coefs    (coefs)
  );

  // two cycles of affine, then two of leaky relu and clamp
  lrelu_affine_stage affine_i (
    .clk      (clk),
    .rst      (rst),
    .clken    (clken),
    .in_ctl   (s_ctl),
    .in_data  (s_data),
    .coefs    (coefs),
    .out_ctl  (mid_ctl),
    .out_data (mid_data)
  );

  lrelu_leaky_stage leaky_i (
    .clk      (clk),
    .rst      (rst),
    .clken    (clken),
    .in_ctl   (mid_ctl),
    .in_data  (mid_data),
    .coefs    (coefs),
    .out_ctl  (m_ctl),
    .out_data (m_data)
  );

endmodule

// ==== tb_lrelu_engine.sv ====
`include "lrelu_defines.svh"

module tb_lrelu_engine;
  timeunit 1ns;
  timeprecision 1ps;

  import lrelu_pkg::*;
  import lrelu_cfg_pkg::*;

  localparam int CFG_WORDS = 1 + 2 * `LRELU_UNITS;
  // the accepting edge is the first of four enabled edges
  localparam int LAT_EDGES = 3;
  // bound on the drain after a burst
  localparam int DRAIN_EDGES = 2 * (LAT_EDGES + 1);
  // 3 loads of 9 words, 400 beats at 50% gaps, one stalled burst, idle drains
  localparam int MAX_CYCLES = 2000;
  localparam longint OUT_HI = (longint'(1) <<< (`LRELU_WORD_OUT - 1)) - 1;
  localparam longint OUT_LO = -(longint'(1) <<< (`LRELU_WORD_OUT - 1));

  typedef struct packed {
    data_out_t   data;
    logic        last;
    lrelu_user_t user;
    logic [31:0] edge_idx;
  } exp_beat_t;

  logic        clk;
  logic        rst;
  logic        clken;
  logic        s_valid;
  logic        s_last;
  lrelu_user_t s_user;
  data_in_t    s_data;
  logic        cfg_valid;
  cfg_word_t   cfg_data;
  logic        m_valid;
  logic        m_last;
  lrelu_user_t m_user;
  data_out_t   m_data;
  logic        count_config_full;

  integer    seed;
  string     test_name;
  int        errors;
  int        beats_checked;
  int        cycles;
  int        en_count;
  int        cfg_pos;
  logic      edge_en;
  logic      full_model;
  coef_set_t model_coefs;
  exp_beat_t exp_q[$];

  lrelu_engine dut_i (
    .clk               (clk),
    .rst               (rst),
    .clken             (clken),
    .s_valid           (s_valid),
    .s_last            (s_last),
    .s_user            (s_user),
    .s_data            (s_data),
    .cfg_valid         (cfg_valid),
    .cfg_data          (cfg_data),
    .m_valid           (m_valid),
    .m_last            (m_last),
    .m_user            (m_user),
    .m_data            (m_data),
    .count_config_full (count_config_full)
  );

  always #50 clk = ~clk;

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic int rand_span(int span);
    return $random(seed) % span;
  endfunction

  // scale, bias, optional leak, offset, clamp
  function automatic word_out_t model_word(word_in_t x, cfg_word_t a, cfg_word_t b,
                                           cfg_word_t d, logic leaky);
    longint p;
    longint q;
    longint r;
    p = ((longint'(x) * longint'(a)) >>> `LRELU_FRAC_BITS) + longint'(b);
    if (leaky && p < 0) begin
      q = (p * `LRELU_ALPHA) >>> `LRELU_ALPHA_SHIFT;
    end else begin
      q = p;
    end
    r = q + longint'(d);
    if (r > OUT_HI) begin
      r = OUT_HI;
    end else if (r < OUT_LO) begin
      r = OUT_LO;
    end
    return word_out_t'(r);
  endfunction

  task automatic check_beat(exp_beat_t exp);
    beats_checked++;
    assert (m_data === exp.data) else begin
      errors++;
      $display("Error %s: m_data expected %h actual %h", test_name, exp.data, m_data);
    end
    assert (m_last === exp.last) else begin
      errors++;
      $display("Error %s: m_last expected %b actual %b", test_name, exp.last, m_last);
    end
    assert (m_user === exp.user) else begin
      errors++;
      $display("Error %s: m_user expected %h actual %h", test_name, exp.user, m_user);
    end
    assert (en_count - int'(exp.edge_idx) == LAT_EDGES) else begin
      errors++;
      $display("Error %s: latency expected %0d actual %0d", test_name, LAT_EDGES + 1,
               en_count - int'(exp.edge_idx) + 1);
    end
  endtask

  task automatic load_config(bit big, int stall_pct);
    cfg_word_t words [0:CFG_WORDS-1];
    int        k;
    logic      en;
    for (k = 0; k < CFG_WORDS; k++) begin
      if (big) begin
        words[k] = cfg_word_t'($random(seed));
      end else if (k == 0) begin
        words[k] = cfg_word_t'(rand_span(16));
      end else if (k <= `LRELU_UNITS) begin
        words[k] = cfg_word_t'(rand_span(64));
      end else begin
        words[k] = cfg_word_t'(rand_span(32));
      end
    end
    k = 0;
    while (k < CFG_WORDS) begin
      @(posedge clk);
      en = (rand_below(100) >= stall_pct);
      clken     <= en;
      cfg_valid <= 1'b1;
      cfg_data  <= words[k];
      if (en) begin
        k++;
      end
    end
    @(posedge clk);
    clken     <= 1'b1;
    cfg_valid <= 1'b0;
  endtask

  task automatic drive_burst(int n_beats, int lrelu_pct, int stall_pct, bit big);
    int   sent;
    int   u;
    logic en;
    sent = 0;
    while (sent < n_beats) begin
      @(posedge clk);
      en = (rand_below(100) >= stall_pct);
      clken <= en;
      for (u = 0; u < `LRELU_UNITS; u++) begin
        s_data[u] <= big ? word_in_t'($random(seed)) : word_in_t'(rand_span(512));
      end
      s_user.is_lrelu <= (rand_below(100) < lrelu_pct);
      s_user.tag      <= rand_below(1 << `LRELU_TAG_WIDTH);
      s_last          <= (rand_below(8) == 0);
      // half of the cycles are idle gaps
      if (rand_below(2) == 0) begin
        s_valid <= 1'b1;
        if (en) begin
          sent++;
        end
      end else begin
        s_valid <= 1'b0;
      end
    end
  endtask

  task automatic wait_idle();
    int drain;
    drain = 0;
    @(posedge clk);
    clken     <= 1'b1;
    s_valid   <= 1'b0;
    cfg_valid <= 1'b0;
    while (exp_q.size() != 0 && drain < DRAIN_EDGES) begin
      @(posedge clk);
      drain++;
    end
  endtask

  // inputs are stable at the falling edge, outputs reflect the last rising edge
  always @(negedge clk) begin : monitor
    exp_beat_t exp;
    int        u;
    if (!rst) begin
      assert (count_config_full === full_model) else begin
        errors++;
        $display("Error %s: count_config_full expected %b actual %b", test_name,
                 full_model, count_config_full);
      end
      if (edge_en && m_valid === 1'b1) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("output beat appeared in %s with no input beat outstanding", test_name);
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          check_beat(exp);
        end
      end
      if (clken) begin
        en_count++;
        if (s_valid) begin
          exp.last     = s_last;
          exp.user     = s_user;
          exp.edge_idx = en_count;
          for (u = 0; u < `LRELU_UNITS; u++) begin
            exp.data[u] = model_word(s_data[u], model_coefs.a[u], model_coefs.b[u],
                                     model_coefs.d, s_user.is_lrelu);
          end
          exp_q.push_back(exp);
        end
        if (cfg_valid) begin
          if (cfg_pos == 0) begin
            model_coefs.d = cfg_data;
          end else if (cfg_pos <= `LRELU_UNITS) begin
            model_coefs.a[cfg_pos - 1] = cfg_data;
          end else begin
            model_coefs.b[cfg_pos - 1 - `LRELU_UNITS] = cfg_data;
          end
          full_model = (cfg_pos == CFG_WORDS - 1);
          cfg_pos    = (cfg_pos + 1) % CFG_WORDS;
        end
      end
    end
    edge_en = clken && !rst;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("summary: %0d beats checked, %0d errors", beats_checked, errors);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    clken         = 1'b1;
    s_valid       = 1'b0;
    s_last        = 1'b0;
    s_user        = '0;
    s_data        = '0;
    cfg_valid     = 1'b0;
    cfg_data      = '0;
    seed          = 23576;
    test_name     = "reset";
    errors        = 0;
    beats_checked = 0;
    cycles        = 0;
    en_count      = 0;
    cfg_pos       = 0;
    edge_en       = 1'b0;
    full_model    = 1'b0;
    model_coefs   = '0;

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    test_name = "config_flag";
    load_config(1'b0, 0);
    test_name = "affine";
    drive_burst(100, 0, 0, 1'b0);
    wait_idle();
    test_name = "leaky";
    drive_burst(100, 70, 0, 1'b0);
    wait_idle();
    // new coefficients between bursts
    test_name = "saturate";
    load_config(1'b1, 0);
    drive_burst(100, 50, 0, 1'b1);
    wait_idle();
    test_name = "reload_stall";
    load_config(1'b0, 20);
    drive_burst(100, 50, 25, 1'b0);
    wait_idle();

    repeat (4) @(posedge clk);
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%0d expected beats never came out of the pipeline", exp_q.size());
    end
    $display("summary: %0d beats checked, %0d errors", beats_checked, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
lrelu_pkg.sv
lrelu_cfg_pkg.sv
lrelu_config_ctrl.sv
lrelu_coef_bank.sv
lrelu_affine_stage.sv
lrelu_leaky_stage.sv
lrelu_engine.sv
tb_lrelu_engine.sv
